// ==== filelist.f ====
+incdir+rtl
rtl/gauss_pkg.sv
rtl/row_delay_line.sv
rtl/mac_tap.sv
rtl/mac_chain.sv
rtl/gauss_filter_top.sv
bench/gauss_filter_props.sv
bench/gauss_filter_tb.sv

// ==== Bender.yml ====
package:
  name: gauss_filter

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gauss_pkg.sv
      - rtl/row_delay_line.sv
      - rtl/mac_tap.sv
      - rtl/mac_chain.sv
      - rtl/gauss_filter_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/gauss_filter_props.sv
      - bench/gauss_filter_tb.sv

// ==== bench/gauss_filter_tb.sv ====
`timescale 1ns/100ps

`include "gauss_consts.svh"

module gauss_filter_tb;

  localparam int TBL_MAX  = 640;                    // room for every stimulus phase
  localparam int GAP      = 30;                     // idle rows, longer than one window
  localparam int FLAT_LEN = 40;                     // rows of constant input
  localparam int RAND_LEN = 200;                    // rows of random input
  localparam logic [`PIX_W-1:0] FLAT_V = 8'd100;    // flat field level
  localparam logic signed [`COEF_W-1:0] kern [`TAP_COUNT] = `GAUSS_KERNEL;

  logic             clk;
  logic             rst;
  logic [`PIX_W-1:0] pa;
  logic [`PIX_W-1:0] pb;
  logic [`PIX_W-1:0] pc;
  logic [`PIX_W-1:0] pd;
  logic [`PIX_W-1:0] pe;
  logic [`PIX_W-1:0] p_out;

  logic [`PIX_W-1:0] stim [TBL_MAX][`KERNEL_SIZE];  // pa to pe per cycle
  logic [`PIX_W-1:0] exp_out [TBL_MAX];             // model output after that cycle's edge
  logic [`PIX_W-1:0] flat_exp;                      // steady level of the flat field
  int tbl_len = 0;
  int flat_start;                                   // first row of the flat field
  int seed = 16;
  int cycles = 0;
  int checks = 0;
  int value_errs = 0;
  int other_errs = 0;

  gauss_filter_top i_gauss_filter_top (
    .clk   (clk),
    .rst   (rst),
    .pa    (pa),
    .pb    (pb),
    .pc    (pc),
    .pd    (pd),
    .pe    (pe),
    .p_out (p_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                          // 10 ns period
  end

  // pixel field of a full-width sum, same bits as the output slice
  function automatic logic [`PIX_W-1:0] out_slice(input longint acc);
    logic [63:0] bits;
    bits = acc;
    return bits[`OUT_LSB +: `PIX_W];
  endfunction

  task add_row(input logic [`PIX_W-1:0] a, b, c, d, e);
    stim[tbl_len][0] = a;
    stim[tbl_len][1] = b;
    stim[tbl_len][2] = c;
    stim[tbl_len][3] = d;
    stim[tbl_len][4] = e;
    tbl_len++;
  endtask

  task add_idle(input int n);
    for (int i = 0; i < n; i++) add_row(0, 0, 0, 0, 0);
  endtask

  // one full-scale sample on a single row, then a quiet gap
  task add_impulse(input int row);
    for (int r = 0; r < `KERNEL_SIZE; r++) stim[tbl_len][r] = (r == row) ? 8'd255 : 8'd0;
    tbl_len++;
    add_idle(GAP);
  endtask

  task build_table();
    logic [`PIX_W-1:0] rv [`KERNEL_SIZE];
    add_idle(GAP);                                  // quiet output after reset
    for (int r = 0; r < `KERNEL_SIZE; r++) add_impulse(r);   // rows a to e
    flat_start = tbl_len;
    for (int i = 0; i < FLAT_LEN; i++) add_row(FLAT_V, FLAT_V, FLAT_V, FLAT_V, FLAT_V);
    add_idle(GAP);
    for (int i = 0; i < RAND_LEN; i++) begin
      for (int r = 0; r < `KERNEL_SIZE; r++) rv[r] = $random(seed);
      add_row(rv[0], rv[1], rv[2], rv[3], rv[4]);
    end
    add_idle(GAP);                                  // drain the last windows
  endtask

  // p_out after edge n sums kern[5r+j] times row r captured on edge n-26+j
  task compute_expected();
    logic [`PIX_W-1:0] hist [`KERNEL_SIZE][27];    // hist[r][d], captured d edges ago
    longint acc;
    longint ksum;
    for (int r = 0; r < `KERNEL_SIZE; r++)
      for (int d = 0; d < 27; d++) hist[r][d] = '0;  // reset captures count as zero
    for (int n = 0; n < tbl_len; n++) begin
      for (int r = 0; r < `KERNEL_SIZE; r++) begin
        for (int d = 26; d > 0; d--) hist[r][d] = hist[r][d-1];
        hist[r][0] = stim[n][r];
      end
      acc = 0;
      for (int r = 0; r < `KERNEL_SIZE; r++)
        for (int j = 0; j < `KERNEL_SIZE; j++)
          acc += longint'(kern[r*`KERNEL_SIZE+j]) * longint'(hist[r][26-j]);
      exp_out[n] = out_slice(acc);
    end
    ksum = 0;
    for (int k = 0; k < `TAP_COUNT; k++) ksum += longint'(kern[k]);
    flat_exp = out_slice(longint'(FLAT_V) * ksum); // v times kernel sum, wraps like the DUT
  endtask

  task drive_row(input int i);
    pa = stim[i][0];
    pb = stim[i][1];
    pc = stim[i][2];
    pd = stim[i][3];
    pe = stim[i][4];
  endtask

  task check_out(input logic [`PIX_W-1:0] expected, input string what);
    checks++;
    assert (p_out === expected)
    else begin
      $display("[ERROR] p_out %s: expected 0x%02h, actual 0x%02h", what, expected, p_out);
      value_errs++;
    end
  endtask

  task finish_run();
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // run limit, the table plus one pipeline fill plus margin
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= tbl_len + `PIPE_LATENCY + 10) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      other_errs++;
      finish_run();
    end
  end

  initial begin
    rst = 1'b1;
    pa  = '0;
    pb  = '0;
    pc  = '0;
    pd  = '0;
    pe  = '0;
    build_table();
    compute_expected();
    repeat (4) begin
      @(posedge clk);
      #2;
      check_out(8'h00, "during reset");             // every reset edge clears the sum
    end
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < tbl_len; i++) begin
      drive_row(i);                                 // inputs settle on the falling edge
      @(posedge clk);
      #2;                                           // sample well after the edge
      check_out(exp_out[i], $sformatf("row %0d", i));
      if (i >= flat_start + 26 && i < flat_start + FLAT_LEN)
        check_out(flat_exp, $sformatf("flat field row %0d", i));
      @(negedge clk);
    end
    finish_run();
  end

endmodule

// ==== bench/gauss_filter_props.sv ====
`timescale 1ns/100ps

`include "gauss_consts.svh"

module gauss_filter_props
  import gauss_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input pixel_t p_out
);

  // a reset edge empties every delay line and tap
  a_reset_clears: assert property (@(posedge clk) rst |=> p_out == '0)
    else $error("p_out is not zero on the edge after a reset edge");

  // no X may leak out once the pipeline starts from its cleared state
  a_no_unknown: assert property (@(posedge clk) disable iff (rst) !$isunknown(p_out))
    else $error("p_out has unknown bits after reset");

  // first sample after reset needs PIPE_LATENCY edges to reach the output
  a_fill_quiet: assert property (
    @(posedge clk) $fell(rst) |=> (p_out == '0) [* `PIPE_LATENCY]
  ) else $error("p_out is nonzero while the pipeline is still filling");

endmodule

bind gauss_filter_top gauss_filter_props u_props (
  .clk   (clk),
  .rst   (rst),
  .p_out (p_out)
);

// ==== rtl/gauss_filter_top.sv ====
`timescale 1ns/100ps

`include "gauss_consts.svh"

module gauss_filter_top
  import gauss_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pa,                       // row a sample, goes straight to the taps
  input  pixel_t pb,                       // rows b to e arrive in the same clock as pa
  input  pixel_t pc,
  input  pixel_t pd,
  input  pixel_t pe,
  output pixel_t p_out                     // blurred pixel, one per clock
);

  pixel_t pb_dly;                          // row b, 5 clocks late
  pixel_t pc_dly;                          // row c, 10 clocks late
  pixel_t pd_dly;                          // row d, 15 clocks late
  pixel_t pe_dly;                          // row e, 20 clocks late
  sum_t   full_sum;                        // s.17 fixed point window sum

  // each lower row sits five taps further down the cascade,
  // so it has to start five clocks later to meet the same sum
  row_delay_line #(.DEPTH(1 * `ROW_SPACING)) u_dly_b (
    .clk  (clk),
    .rst  (rst),
    .din  (pb),
    .dout (pb_dly)
  );

  row_delay_line #(.DEPTH(2 * `ROW_SPACING)) u_dly_c (
    .clk  (clk),
    .rst  (rst),
    .din  (pc),
    .dout (pc_dly)
  );

  row_delay_line #(.DEPTH(3 * `ROW_SPACING)) u_dly_d (
    .clk  (clk),
    .rst  (rst),
    .din  (pd),
    .dout (pd_dly)
  );

  row_delay_line #(.DEPTH(4 * `ROW_SPACING)) u_dly_e (
    .clk  (clk),
    .rst  (rst),
    .din  (pe),
    .dout (pe_dly)
  );

  mac_chain u_chain (
    .clk   (clk),
    .rst   (rst),
    .row_a (pa),
    .row_b (pb_dly),
    .row_c (pc_dly),
    .row_d (pd_dly),
    .row_e (pe_dly),
    .sum   (full_sum)
  );

  // integer part of the sum, no rounding and no clipping
  assign p_out = full_sum[`OUT_LSB +: `PIX_W];

endmodule

// ==== rtl/mac_chain.sv ====
`timescale 1ns/100ps

`include "gauss_consts.svh"

module mac_chain
  import gauss_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  pixel_t row_a,                    // top row of the window, undelayed
  input  pixel_t row_b,                    // rows b to e already aligned
  input  pixel_t row_c,
  input  pixel_t row_d,
  input  pixel_t row_e,
  output sum_t   sum                       // output of the last tap
);

  // weights in tap order, index 5r+j is row r and column j
  localparam coeff_t KERNEL [`TAP_COUNT] = `GAUSS_KERNEL;

  pixel_t rows [`KERNEL_SIZE];             // row streams indexed by row number
  sum_t   casc [`TAP_COUNT+1];             // casc[k] feeds tap k, casc[k+1] leaves it

  assign rows[0] = row_a;
  assign rows[1] = row_b;
  assign rows[2] = row_c;
  assign rows[3] = row_d;
  assign rows[4] = row_e;

  assign casc[0] = '0;                     // head of the chain adds to nothing

  // five taps share a row stream, each tap sees the sample one clock
  // later in the cascade, so tap 5r+j picks up column j of the window
  for (genvar r = 0; r < `KERNEL_SIZE; r++) begin : g_row
    for (genvar j = 0; j < `KERNEL_SIZE; j++) begin : g_col
      localparam int K = r * `KERNEL_SIZE + j;   // position in cascade order

      mac_tap #(
        .COEF    (KERNEL[K])
      ) u_tap (
        .clk     (clk),
        .rst     (rst),
        .pix     (rows[r]),
        .sum_in  (casc[K]),
        .sum_out (casc[K+1])
      );
    end
  end

  // full 48-bit window sum, fraction bits still attached
  assign sum = casc[`TAP_COUNT];

endmodule

// ==== rtl/mac_tap.sv ====
`timescale 1ns/100ps

module mac_tap
  import gauss_pkg::*;
#(
  parameter coeff_t COEF = '0              // fixed kernel weight of this tap
) (
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pix,                      // row stream for this tap
  input  sum_t   sum_in,                   // partial sum from the previous tap
  output sum_t   sum_out                   // partial sum to the next tap
);

  // weight widened once to product width, sign kept
  localparam product_t COEF_EXT = product_t'(COEF);

  pixel_t   pix_q;                         // stage 1, input register
  product_t pix_ext;                       // pixel zero extended, now a positive signed value
  product_t prod_q;                        // stage 2, product register
  sum_t     sum_q;                         // stage 3, cascade sum register

  assign pix_ext = product_t'(pix_q);      // unsigned source so upper bits fill with zero

  // input register, edge e
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_q <= '0;
    end else begin
      pix_q <= pix;
    end
  end

  // product register, edge e+1
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= pix_ext * COEF_EXT;        // 255 * 2^17 fits in 26 signed bits
    end
  end

  // cascade sum register, edge e+2
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q <= '0;
    end else begin
      sum_q <= sum_in + sum_t'(prod_q);    // sign extend product to 48 bits
    end
  end

  assign sum_out = sum_q;                  // one clock per link of the chain

endmodule

// ==== rtl/row_delay_line.sv ====
`timescale 1ns/100ps

module row_delay_line
  import gauss_pkg::*;
#(
  parameter int DEPTH = 5                  // clocks of delay, 5 to 20 in this design
) (
  input  logic   clk,
  input  logic   rst,
  input  pixel_t din,                      // undelayed row stream
  output pixel_t dout                      // same stream DEPTH clocks later
);

  pixel_t shreg [DEPTH];                   // stage 0 is the newest sample

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        shreg[i] <= '0;                    // flush stale pixels
      end
    end else begin
      shreg[0] <= din;                     // capture on edge e
      for (int i = 1; i < DEPTH; i++) begin
        shreg[i] <= shreg[i-1];            // one stage per clock
      end
    end
  end

  // visible after edge e+DEPTH-1, taken by the tap register on e+DEPTH
  assign dout = shreg[DEPTH-1];

endmodule

// ==== rtl/gauss_pkg.sv ====
`include "gauss_consts.svh"

package gauss_pkg;

  // one 8-bit luminance sample, always non-negative
  typedef logic [`PIX_W-1:0] pixel_t;

  // kernel weight, signed fixed point
  typedef logic signed [`COEF_W-1:0] coeff_t;

  // pixel times weight, 8 + 18 bits holds the full product
  typedef logic signed [`PIX_W+`COEF_W-1:0] product_t;

  // running sum carried from tap to tap
  typedef logic signed [`SUM_W-1:0] sum_t;

endpackage

// ==== rtl/gauss_consts.svh ====
`ifndef GAUSS_CONSTS_SVH
`define GAUSS_CONSTS_SVH

// datapath widths
`define PIX_W          8                    // unsigned pixel
`define COEF_W         18                   // signed kernel weight
`define COEF_INT_BITS  0                    // integer bits of a weight, kernel is tuned for 0
`define SUM_W          48                   // cascade partial sum

// window geometry
`define KERNEL_SIZE    5                    // window is 5x5
`define TAP_COUNT      25                   // one tap per window position
`define ROW_SPACING    5                    // extra delay per lower row, in clocks

// pixel field inside the final sum, weights are s.0.17
`define OUT_LSB        (17 - `COEF_INT_BITS)

// sample to first output effect, last column of row a
`define PIPE_LATENCY   22

// gaussian weights in tap order, row a first, five per row
// format s.(COEF_INT_BITS).(17-COEF_INT_BITS), sum just under 1.0
`define GAUSS_KERNEL '{ \
  18'sh001E0, 18'sh00780, 18'sh00D20, 18'sh00780, 18'sh001E0, \
  18'sh00780, 18'sh01E01, 18'sh030C3, 18'sh01E01, 18'sh00780, \
  18'sh00D20, 18'sh01E01, 18'sh04CE4, 18'sh01E01, 18'sh00D20, \
  18'sh00780, 18'sh01E01, 18'sh030C3, 18'sh01E01, 18'sh00780, \
  18'sh001E0, 18'sh00780, 18'sh00D20, 18'sh00780, 18'sh001E0  \
}

// center weight 18'sh04CE4 is about 0.150
// corner weight 18'sh001E0 is about 0.004
// kernel is symmetric, so the tap order along a row only
// matters for which column lands on which output cycle

`endif
